// File: sim.f
rtl/swc_pkg.sv
rtl/conf_bus_decoder.sv
rtl/conf_mem.sv
rtl/thread_sequencer.sv
rtl/conf_delay_pipe.sv
rtl/switch_conf_control.sv
tests/tb_clock.sv
tests/tb_switch_conf_control.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_switch_conf_control
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := all tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "result: pass"; \
	else \
	  echo "result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/tb_switch_conf_control.sv
module tb_switch_conf_control;

  import swc_pkg::*;

  localparam switch_id_t own_id          = 8'd5;
  localparam switch_id_t foreign_id      = 8'd6;
  localparam int         stage_cnt       = 1;
  localparam int         depth           = stage_cnt + 3;
  localparam int         watchdog_cycles = 20000;

  logic        clk;
  logic        arst_n;
  logic        en_pc_net;
  conf_bus_t   conf_bus_in;
  conf_word_t  switch_conf_out;
  logic [31:0] rng_state;

  // reference model state.
  conf_word_t  m_mem  [mem_depth];
  pc_t         m_pc   [num_threads];
  pc_t         m_max  [num_threads];
  pc_t         m_loop [num_threads];
  thread_id_t  m_thread;
  conf_bus_t   m_pend;
  logic        m_pend_hit;
  logic        model_live;
  conf_word_t  exp_q   [$]; // pipe stages, then the memory read register.
  bit          known_q [$];

  tb_clock #(.PERIOD(20), .RESET_CYCLES(5)) u_clock (.clk(clk), .arst_n(arst_n));

  switch_conf_control #(
    .SWITCH_NUMBER(own_id),
    .STAGE        (stage_cnt)
  ) uut (
    .clk            (clk),
    .arst_n         (arst_n),
    .en_pc_net      (en_pc_net),
    .conf_bus_in    (conf_bus_in),
    .switch_conf_out(switch_conf_out)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic conf_bus_t make_bus(input conf_op_e op, input switch_id_t id,
                                         input thread_id_t thread, input pc_t addr,
                                         input conf_word_t data);
    conf_bus_t b;
    b.op        = op;
    b.switch_id = id;
    b.thread    = thread;
    b.addr      = addr;
    b.data      = data;
    b.reserved  = 35'(next_rand()); // noise on unused bits.
    return b;
  endfunction

  function automatic conf_bus_t idle_bus();
    return make_bus(op_nop, own_id, thread_id_t'(next_rand()), pc_t'(next_rand()),
                    conf_word_t'(next_rand()));
  endfunction

  task automatic abort_run(input string why);
    $display("error: %s", why);
    $display("tests failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_conf(input string name, input conf_word_t actual,
                            input conf_word_t expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s actual=%02h expected=%02h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "output mismatch");
    end
  endtask

  //////////////////////////////
  // reference model
  //////////////////////////////

  function automatic void reset_model();
    for (int i = 0; i < num_threads; i++) begin
      m_pc[i]   = '0;
      m_max[i]  = '0;
      m_loop[i] = '0;
    end
    m_thread   = '0;
    m_pend_hit = 1'b0;
    exp_q.delete();
    known_q.delete();
    for (int i = 0; i <= depth; i++) begin
      exp_q.push_back(8'h00);
      known_q.push_back(i < depth); // read register not loaded yet.
    end
  endfunction

  // applies one network step and returns the byte read before the edge.
  function automatic conf_word_t step_model();
    mem_raddr_t a;
    a.thread = m_thread;
    a.pc     = m_pc[m_thread];
    if (m_pc[m_thread] == m_max[m_thread]) begin
      m_pc[m_thread] = m_loop[m_thread];
    end else begin
      m_pc[m_thread] = m_pc[m_thread] + pc_t'(1);
    end
    m_thread = m_thread + thread_id_t'(1);
    return m_mem[a];
  endfunction

  function automatic void apply_write(input conf_bus_t w);
    mem_raddr_t a;
    a.thread = w.thread;
    a.pc     = w.addr;
    case (w.op)
      op_mem_write: m_mem[a] = w.data;
      op_pc_max:    m_max[w.thread] = pc_t'(w.data);
      op_pc_loop:   m_loop[w.thread] = pc_t'(w.data);
      default:      ;
    endcase
  endfunction

  always @(posedge clk) begin
    conf_word_t rd;
    if (!arst_n) begin
      reset_model();
      model_live = 1'b0;
    end else begin
      model_live = 1'b1;
      if (en_pc_net) begin
        rd = step_model();
        exp_q.push_back(rd);
        known_q.push_back(1'b1);
        void'(exp_q.pop_front());
        void'(known_q.pop_front());
      end
      // write from the decoder register lands one edge later.
      if (m_pend_hit) begin
        apply_write(m_pend);
      end
      m_pend     = conf_bus_in;
      m_pend_hit = (conf_bus_in.switch_id == own_id) && (conf_bus_in.op != op_nop);
    end
  end

  // outputs only move on rising edges.
  always @(negedge clk) begin
    if (model_live && known_q[0]) begin
      check_conf("switch_conf_out", switch_conf_out, exp_q[0]);
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  task automatic drive(input logic en, input conf_bus_t bus);
    @(negedge clk);
    en_pc_net   = en;
    conf_bus_in = bus;
  endtask

  task automatic run_steps(input int n);
    for (int i = 0; i < n; i++) begin
      drive(1'b1, idle_bus());
    end
  endtask

  task automatic wait_reset_release(input int limit);
    int n;
    n = 0;
    while (arst_n !== 1'b1 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      abort_run("reset was not released in time");
    end
  endtask

  initial begin
    for (int i = 0; i < watchdog_cycles; i++) begin
      @(posedge clk);
    end
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    mem_raddr_t  wa;
    logic [31:0] r;
    pc_t         mx;
    pc_t         lp;
    thread_id_t  nt;
    conf_bus_t   bus;
    rng_state   = 32'hafc04d99;
    en_pc_net   = 1'b0;
    conf_bus_in = '0;
    wait_reset_release(20);

    // full memory load with the network idle.
    for (int a = 0; a < mem_depth; a++) begin
      wa = mem_raddr_t'(a[10:0]);
      drive(1'b0, make_bus(op_mem_write, own_id, wa.thread, wa.pc, conf_word_t'(next_rand())));
    end
    drive(1'b0, idle_bus());
    drive(1'b0, idle_bus());

    run_steps(depth);  // pipe drains reset zeros.
    run_steps(64);     // zero bounds keep every thread at offset 0.

    // loop bounds.
    for (int t = 0; t < num_threads; t++) begin
      mx = pc_t'(next_rand() % 32'd24);
      lp = pc_t'(next_rand() % (32'(mx) + 32'd1));
      drive(1'b0, make_bus(op_pc_max, own_id, thread_id_t'(t), '0, conf_word_t'(mx)));
      drive(1'b0, make_bus(op_pc_loop, own_id, thread_id_t'(t), '0, conf_word_t'(lp)));
    end
    drive(1'b0, idle_bus());
    drive(1'b0, idle_bus());
    run_steps(600);

    // traffic for another switch.
    for (int i = 0; i < 240; i++) begin
      r = next_rand();
      case (r % 32'd3)
        32'd0: bus = make_bus(op_mem_write, foreign_id, thread_id_t'(r >> 8),
                              pc_t'(r >> 12), conf_word_t'(r >> 20));
        32'd1: bus = make_bus(r[4] ? op_pc_max : op_pc_loop, foreign_id,
                              thread_id_t'(r >> 8), '0, conf_word_t'(r >> 20));
        default: bus = idle_bus();
      endcase
      drive(1'b1, bus);
    end

    // enable with gaps.
    for (int i = 0; i < 400; i++) begin
      r = next_rand();
      drive(r[2:0] > 3'd2, idle_bus());
    end

    // reconfiguration while running.
    for (int i = 0; i < 400; i++) begin
      @(negedge clk);
      r  = next_rand();
      nt = m_thread + thread_id_t'(1); // read on the edge the write lands.
      case (r[2:0])
        3'd0, 3'd1: bus = make_bus(op_mem_write, own_id, nt, m_pc[nt], conf_word_t'(r >> 8));
        3'd2: bus = make_bus(op_mem_write, own_id, thread_id_t'(r >> 8),
                             pc_t'(r >> 12), conf_word_t'(r >> 20));
        3'd3: bus = make_bus(op_pc_max, own_id, thread_id_t'(r >> 8), '0,
                             conf_word_t'((r >> 12) % 32'd24));
        3'd4: bus = make_bus(op_pc_loop, own_id, thread_id_t'(r >> 8), '0,
                             conf_word_t'((r >> 12) % 32'd24));
        default: bus = idle_bus();
      endcase
      en_pc_net   = 1'b1;
      conf_bus_in = bus;
    end

    run_steps(depth + 2);
    drive(1'b0, idle_bus());
    @(posedge clk);
    $display("all tests passed");
    $finish;
  end

endmodule

// File: tests/tb_clock.sv
module tb_clock #(
  parameter int PERIOD       = 20,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release on a falling edge, away from the sampling edge.
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule

// File: rtl/switch_conf_control.sv
module switch_conf_control #(
  parameter swc_pkg::switch_id_t SWITCH_NUMBER = '0,
  parameter int                  STAGE         = 1
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                en_pc_net,
  input  swc_pkg::conf_bus_t  conf_bus_in,
  output swc_pkg::conf_word_t switch_conf_out
);

  import swc_pkg::*;

  mem_write_t   mem_write;
  bound_write_t bound_write;
  mem_raddr_t   mem_raddr;
  conf_word_t   mem_dout;

  conf_bus_decoder #(
    .SWITCH_NUMBER(SWITCH_NUMBER)
  ) u_decoder (
    .clk        (clk),
    .arst_n     (arst_n),
    .conf_bus_in(conf_bus_in),
    .mem_write  (mem_write),
    .bound_write(bound_write)
  );

  thread_sequencer u_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .en         (en_pc_net),
    .bound_write(bound_write),
    .raddr      (mem_raddr)
  );

  conf_mem u_mem (
    .clk      (clk),
    .mem_write(mem_write),
    .re       (en_pc_net), // one read per step.
    .raddr    (mem_raddr),
    .dout     (mem_dout)
  );

  // output retiming.
  conf_delay_pipe #(
    .DEPTH(STAGE + 3)
  ) u_delay (
    .clk   (clk),
    .arst_n(arst_n),
    .en    (en_pc_net),
    .din   (mem_dout),
    .dout  (switch_conf_out)
  );

endmodule

// File: rtl/conf_delay_pipe.sv
module conf_delay_pipe #(
  parameter int DEPTH = 4
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                en,
  input  swc_pkg::conf_word_t din,
  output swc_pkg::conf_word_t dout
);

  import swc_pkg::*;

  conf_word_t stage [DEPTH];

  // only moves on a network step.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else if (en) begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign dout = stage[DEPTH-1];

endmodule

// File: rtl/thread_sequencer.sv
module thread_sequencer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  en,
  input  swc_pkg::bound_write_t bound_write,
  output swc_pkg::mem_raddr_t   raddr
);

  import swc_pkg::*;

  pc_t        pc_max  [num_threads];
  pc_t        pc_loop [num_threads];
  pc_t        pc      [num_threads];
  thread_id_t thread_idx;
  thread_id_t thread_nxt;
  pc_t        pc_cur;
  pc_t        pc_nxt;

  ////////////////////////////////
  // loop bounds
  ////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_threads; i++) begin
        pc_max[i]  <= '0;
        pc_loop[i] <= '0;
      end
    end else begin
      if (bound_write.max_we) begin
        pc_max[bound_write.thread] <= bound_write.value;
      end
      if (bound_write.loop_we) begin
        pc_loop[bound_write.thread] <= bound_write.value;
      end
    end
  end

  ////////////////////////////////
  // program counters
  ////////////////////////////////

  assign pc_cur = pc[thread_idx];

  always_comb begin
    if (pc_cur == pc_max[thread_idx]) begin
      pc_nxt = pc_loop[thread_idx]; // loop back.
    end else begin
      pc_nxt = pc_cur + pc_t'(1);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < num_threads; i++) begin
        pc[i] <= '0;
      end
    end else if (en) begin
      pc[thread_idx] <= pc_nxt;
    end
  end

  // round robin over the threads.
  assign thread_nxt = (thread_idx == thread_id_t'(num_threads - 1)) ? '0
                                                                    : thread_idx + thread_id_t'(1);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thread_idx <= '0;
    end else if (en) begin
      thread_idx <= thread_nxt;
    end
  end

  assign raddr.thread = thread_idx;
  assign raddr.pc     = pc_cur;

endmodule

// File: rtl/conf_mem.sv
module conf_mem (
  input  logic                clk,
  input  swc_pkg::mem_write_t mem_write,
  input  logic                re,
  input  swc_pkg::mem_raddr_t raddr,
  output swc_pkg::conf_word_t dout
);

  import swc_pkg::*;

  conf_word_t mem [mem_depth];
  mem_raddr_t waddr;

  assign waddr.thread = mem_write.thread;
  assign waddr.pc     = mem_write.addr;

  // write port.
  always_ff @(posedge clk) begin
    if (mem_write.we) begin
      mem[waddr] <= mem_write.data;
    end
  end

  // registered read, old data on a same-address write.
  always_ff @(posedge clk) begin
    if (re) begin
      dout <= mem[raddr];
    end
  end

endmodule

// File: rtl/conf_bus_decoder.sv
module conf_bus_decoder #(
  parameter swc_pkg::switch_id_t SWITCH_NUMBER = '0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  swc_pkg::conf_bus_t    conf_bus_in,
  output swc_pkg::mem_write_t   mem_write,
  output swc_pkg::bound_write_t bound_write
);

  import swc_pkg::*;

  logic       hit;
  logic       mem_we_d;
  logic       max_we_d;
  logic       loop_we_d;

  logic       mem_we_q;
  logic       max_we_q;
  logic       loop_we_q;
  thread_id_t thread_q;
  pc_t        addr_q;
  conf_word_t data_q;

  ////////////////////////////////
  // decode
  ////////////////////////////////

  assign hit = (conf_bus_in.switch_id == SWITCH_NUMBER);

  always_comb begin
    mem_we_d  = 1'b0;
    max_we_d  = 1'b0;
    loop_we_d = 1'b0;
    if (hit) begin
      case (conf_bus_in.op)
        op_mem_write: mem_we_d  = 1'b1;
        op_pc_max:    max_we_d  = 1'b1;
        op_pc_loop:   loop_we_d = 1'b1;
        default:      ; // op_nop, idle bus.
      endcase
    end
  end

  ////////////////////////////////
  // registers
  ////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_we_q  <= 1'b0;
      max_we_q  <= 1'b0;
      loop_we_q <= 1'b0;
    end else begin
      mem_we_q  <= mem_we_d;
      max_we_q  <= max_we_d;
      loop_we_q <= loop_we_d;
    end
  end

  always_ff @(posedge clk) begin
    thread_q <= conf_bus_in.thread;
    addr_q   <= conf_bus_in.addr;
    data_q   <= conf_bus_in.data;
  end

  assign mem_write.we     = mem_we_q;
  assign mem_write.thread = thread_q;
  assign mem_write.addr   = addr_q;
  assign mem_write.data   = data_q;

  // bound value comes in on the data field.
  assign bound_write.max_we  = max_we_q;
  assign bound_write.loop_we = loop_we_q;
  assign bound_write.thread  = thread_q;
  assign bound_write.value   = pc_t'(data_q);

endmodule

// File: rtl/swc_pkg.sv
package swc_pkg;

  ////////////////////////////////
  // sizes
  ////////////////////////////////

  localparam int num_threads = 8;
  localparam int thread_w    = $clog2(num_threads);
  localparam int pc_w        = 8;
  localparam int mem_depth   = num_threads << pc_w; // 2048 bytes.

  typedef logic [thread_w-1:0] thread_id_t;
  typedef logic [pc_w-1:0]     pc_t;
  typedef logic [7:0]          conf_word_t;
  typedef logic [7:0]          switch_id_t;

  ////////////////////////////////
  // bus word
  ////////////////////////////////

  typedef enum logic [1:0] {
    op_nop       = 2'd0,
    op_pc_max    = 2'd1,
    op_pc_loop   = 2'd2,
    op_mem_write = 2'd3
  } conf_op_e;

  // op sits in the top bits, reserved fills the bottom.
  typedef struct packed {
    conf_op_e    op;
    switch_id_t  switch_id;
    thread_id_t  thread;
    pc_t         addr;
    conf_word_t  data;
    logic [34:0] reserved;
  } conf_bus_t;

  ////////////////////////////////
  // internal
  ////////////////////////////////

  typedef struct packed {
    logic       we;
    thread_id_t thread;
    pc_t        addr;
    conf_word_t data;
  } mem_write_t;

  typedef struct packed {
    logic       max_we;
    logic       loop_we;
    thread_id_t thread;
    pc_t        value;
  } bound_write_t;

  // thread in the upper bits, one 256-byte page per thread.
  typedef struct packed {
    thread_id_t thread;
    pc_t        pc;
  } mem_raddr_t;

endpackage
